/* dv/ir_decoder_props.sv */
`default_nettype none

module ir_decoder_props (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input logic                                  valid_o,
  input logic                                  illegal_insn_o,
  input logic                                  perm_vio_o,
  input logic                                  bound_vio_o,
  input logic                                  fetch_err_o,
  input logic                                  any_err_o,
  input logic [ir_decoder_pkg::REG_ADDR_W-1:0] rs1_o,
  input logic [1:0]                            rf_ren_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // nothing leaves the stage while reset is held
  a_no_valid_in_reset : assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
    else $error("valid_o high while reset is asserted");

  a_any_err_sum : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> (any_err_o == (illegal_insn_o | perm_vio_o | bound_vio_o | fetch_err_o)))
    else $error("any_err_o differs from the OR of the error outputs");

  a_rs1_zero_unread : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !rf_ren_o[0] |-> (rs1_o == '0))
    else $error("rs1_o nonzero while port a is not read");

endmodule

bind ir_decoder ir_decoder_props i_props (.*);

`default_nettype wire

/* dv/ir_decoder_tb.sv */
`default_nettype none

module ir_decoder_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ir_decoder_pkg::*;

  typedef struct packed {
    logic [31:0] insn;
    logic [31:0] pc;
    logic        comp;
    logic        ferr;
    logic        cheri;
    logic        dbg;
    logic [31:0] base;
    logic [32:0] top;
    logic        tag;
    logic        perm_ex;
    logic        perm_sr;
    logic [2:0]  otype;
  } stim_t;

  typedef struct packed {
    logic                  vld;
    logic [PL_W-1:0]       pl;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [1:0]            ren;
    logic                  we;
    logic [3:0]            errs;   // {illegal, perm, bound, fetch}
    logic                  any;
    logic [SYSCTL_W-1:0]   sys;
    logic [2:0]            ctl;    // {branch, jal, jalr}
    logic [31:0]           pc_nxt;
    logic [31:0]           btarget;
  } exp_t;

  logic                  clk_i, rst_n_i, valid_i;
  logic [XLEN-1:0]       insn_i, pc_i, pcc_base_i;
  logic                  is_comp_i, fetch_err_i, cheri_pmode_i, debug_mode_i;
  logic [XLEN:0]         pcc_top_i;
  logic                  pcc_tag_i, pcc_perm_ex_i, pcc_perm_sr_i;
  logic [OTYPE_W-1:0]    pcc_otype_i;
  logic                  valid_o, rf_we_o, illegal_insn_o, perm_vio_o, bound_vio_o;
  logic                  fetch_err_o, any_err_o, is_branch_o, is_jal_o, is_jalr_o;
  logic [PL_W-1:0]       pl_type_o;
  logic [REG_ADDR_W-1:0] rs1_o, rs2_o, rd_o;
  logic [1:0]            rf_ren_o;
  logic [SYSCTL_W-1:0]   sysctl_o;
  logic [XLEN-1:0]       pc_nxt_o, btarget_o;

  stim_t tmpl;          // inputs shared by the rows that follow
  stim_t stim_q[$];
  exp_t  exp_q[$];
  exp_t  pend_q[$];     // one expected entry per driven cycle

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  ir_decoder i_dut (.*);

  //////////////////////////////////////////////////////////////////////
  // instruction builders and expected targets
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] mk_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
    insn_word_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = op;
    return w;
  endfunction

  function automatic logic [31:0] mk_sys(input logic [11:0] f12, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    insn_word_u w;
    w.s.funct12 = f12;
    w.s.rs1     = rs1;
    w.s.funct3  = f3;
    w.s.rd      = rd;
    w.s.opcode  = OPCODE_SYSTEM;
    return w;
  endfunction

  // jal uses the j-immediate and everything else the b-immediate
  function automatic logic [31:0] target_of(input logic [31:0] insn, input logic [31:0] pc);
    logic [31:0] off;
    if (insn[6:0] == OPCODE_JAL) begin
      off = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end else begin
      off = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    end
    return pc + off;
  endfunction

  function automatic stim_t dflt_stim();
    stim_t s;
    s         = '0;
    s.pc      = 32'h0000_1000;
    s.top     = 33'h1_0000_0000;   // whole address space
    s.tag     = 1'b1;
    s.perm_ex = 1'b1;
    s.perm_sr = 1'b1;
    return s;
  endfunction

  task automatic row(input logic [31:0] insn, input logic [PL_W-1:0] pl,
                     input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                     input logic [1:0] ren, input logic we, input logic [3:0] errs,
                     input logic [SYSCTL_W-1:0] sys);
    stim_t s;
    exp_t  e;
    s         = tmpl;
    s.insn    = insn;
    e.vld     = 1'b1;
    e.pl      = pl;
    e.rs1     = rs1;
    e.rs2     = rs2;
    e.rd      = rd;
    e.ren     = ren;
    e.we      = we;
    e.errs    = errs;
    e.any     = |errs;
    e.sys     = sys;
    e.ctl     = {insn[6:0] == OPCODE_BRANCH, insn[6:0] == OPCODE_JAL,
                 insn[6:0] == OPCODE_JALR};
    e.pc_nxt  = s.pc + (s.comp ? 32'd2 : 32'd4);
    e.btarget = target_of(insn, s.pc);
    stim_q.push_back(s);
    exp_q.push_back(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and compare
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_row(input exp_t e);
    check_val("valid_o", 32'(valid_o), 32'(e.vld));
    if (e.vld) begin
      check_val("pl_type_o", 32'(pl_type_o), 32'(e.pl));
      check_val("rs1_o", 32'(rs1_o), 32'(e.rs1));
      check_val("rs2_o", 32'(rs2_o), 32'(e.rs2));
      check_val("rd_o", 32'(rd_o), 32'(e.rd));
      check_val("rf_ren_o", 32'(rf_ren_o), 32'(e.ren));
      check_val("rf_we_o", 32'(rf_we_o), 32'(e.we));
      check_val("illegal_insn_o", 32'(illegal_insn_o), 32'(e.errs[3]));
      check_val("perm_vio_o", 32'(perm_vio_o), 32'(e.errs[2]));
      check_val("bound_vio_o", 32'(bound_vio_o), 32'(e.errs[1]));
      check_val("fetch_err_o", 32'(fetch_err_o), 32'(e.errs[0]));
      check_val("any_err_o", 32'(any_err_o), 32'(e.any));
      check_val("sysctl_o", 32'(sysctl_o), 32'(e.sys));
      check_val("is_branch_o", 32'(is_branch_o), 32'(e.ctl[2]));
      check_val("is_jal_o", 32'(is_jal_o), 32'(e.ctl[1]));
      check_val("is_jalr_o", 32'(is_jalr_o), 32'(e.ctl[0]));
      check_val("pc_nxt_o", pc_nxt_o, e.pc_nxt);
      check_val("btarget_o", btarget_o, e.btarget);
    end
  endtask

  task automatic drive(input stim_t s, input logic vld);
    valid_i       = vld;
    insn_i        = s.insn;
    pc_i          = s.pc;
    is_comp_i     = s.comp;
    fetch_err_i   = s.ferr;
    cheri_pmode_i = s.cheri;
    debug_mode_i  = s.dbg;
    pcc_base_i    = s.base;
    pcc_top_i     = s.top;
    pcc_tag_i     = s.tag;
    pcc_perm_ex_i = s.perm_ex;
    pcc_perm_sr_i = s.perm_sr;
    pcc_otype_i   = s.otype;
  endtask

  // result of the previous cycle is settled 1 ns after the edge
  task automatic advance();
    @(posedge clk_i);
    #1;
    if (pend_q.size() > 0) begin
      compare_row(pend_q.pop_front());
    end
  endtask

  task automatic idle_cycle();
    stim_t       s;
    exp_t        e;
    logic [31:0] r;
    r         = $urandom;
    s.insn    = $urandom;
    s.pc      = $urandom;
    s.base    = $urandom;
    s.top     = {r[0], pc_i ^ s.pc};
    s.comp    = r[1];
    s.ferr    = r[2];
    s.cheri   = r[3];
    s.dbg     = r[4];
    s.tag     = r[5];
    s.perm_ex = r[6];
    s.perm_sr = r[7];
    s.otype   = r[10:8];
    e         = '0;   // only valid_o low is expected
    advance();
    drive(s, 1'b0);
    pend_q.push_back(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    tmpl = dflt_stim();
    // classification
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),   // add x3, x1, x2
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h0, 7'h00);
    row(mk_r(7'h00, 5'd8, 5'd6, 3'd2, 5'd5, OPCODE_LOAD),   // lw x5, 8(x6)
        PL_LS, 5'd6, 5'd0, 5'd5, 2'b01, 1'b1, 4'h0, 7'h00);
    row(mk_r(7'h00, 5'd7, 5'd8, 3'd2, 5'd4, OPCODE_STORE),   // sw x7, 4(x8)
        PL_LS, 5'd8, 5'd7, 5'd0, 2'b11, 1'b0, 4'h0, 7'h00);
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd16, OPCODE_BRANCH),   // beq +16
        PL_LOCAL, 5'd1, 5'd2, 5'd0, 2'b11, 1'b0, 4'h0, 7'h00);
    row(mk_r(7'h7f, 5'd2, 5'd1, 3'd1, 5'd25, OPCODE_BRANCH),   // bne -8
        PL_LOCAL, 5'd1, 5'd2, 5'd0, 2'b11, 1'b0, 4'h0, 7'h00);
    row(mk_r(7'h08, 5'd0, 5'd0, 3'd0, 5'd1, OPCODE_JAL),   // jal x1, +0x100
        PL_JAL, 5'd0, 5'd0, 5'd1, 2'b00, 1'b1, 4'h0, 7'h00);
    row(mk_r(7'h00, 5'd0, 5'd1, 3'd0, 5'd0, OPCODE_JALR),
        PL_JALR, 5'd1, 5'd0, 5'd0, 2'b01, 1'b1, 4'h0, 7'h00);
    row(mk_r(7'h01, 5'd12, 5'd11, 3'd0, 5'd10, OPCODE_OP),   // mul
        PL_MULT, 5'd11, 5'd12, 5'd10, 2'b11, 1'b1, 4'h0, 7'h00);
    row(32'h1234_54b7, PL_ALU, 5'd0, 5'd0, 5'd9, 2'b00, 1'b1, 4'h0, 7'h00);   // lui x9
    // illegal encodings
    row(32'h0000_000b, PL_ALU, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h8, 7'h00);
    row(mk_r(7'h00, 5'd0, 5'd1, 3'd1, 5'd2, OPCODE_JALR),
        PL_JALR, 5'd1, 5'd0, 5'd2, 2'b01, 1'b1, 4'h8, 7'h00);
    row(mk_r(7'h00, 5'd7, 5'd8, 3'd4, 5'd4, OPCODE_STORE),
        PL_LS, 5'd8, 5'd7, 5'd0, 2'b11, 1'b0, 4'h8, 7'h00);
    row(mk_sys(12'h000, 5'd0, 3'd0, 5'd1),   // ecall with rd = x1
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h8, 7'h01);
    // x17 lies outside the cheriot register range
    tmpl.cheri = 1'b1;
    row(mk_r(7'h00, 5'd2, 5'd17, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h8, 7'h00);
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h0, 7'h00);
    // fetch bounds
    tmpl.base = 32'h0000_2000;
    tmpl.top  = 33'h0_0000_3000;
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),   // pc below base
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h2, 7'h00);
    tmpl.base = 32'h0000_1000;
    tmpl.top  = 33'h0_0000_2000;
    tmpl.pc   = 32'h0000_1ffd;   // 3 bytes of headroom
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h2, 7'h00);
    tmpl.comp = 1'b1;
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h0, 7'h00);
    tmpl.comp = 1'b0;
    tmpl.base = 32'h0;
    tmpl.top  = 33'h1_0000_0000;
    tmpl.pc   = 32'hffff_fffe;   // wrapping fetch that is still allowed
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h0, 7'h00);
    // permissions
    tmpl.pc  = 32'h0000_1000;
    tmpl.tag = 1'b0;
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h4, 7'h00);
    tmpl.tag     = 1'b1;
    tmpl.perm_sr = 1'b0;
    row(mk_sys(12'h302, 5'd0, 3'd0, 5'd0),   // mret
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h4, 7'h04);
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),   // sr only matters for mret
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h0, 7'h00);
    // debug mode hides every capability error
    tmpl.dbg  = 1'b1;
    tmpl.tag  = 1'b0;
    tmpl.base = 32'h0000_2000;
    tmpl.top  = 33'h0_0000_3000;
    row(mk_sys(12'h302, 5'd0, 3'd0, 5'd0),
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h0, 7'h04);
    tmpl      = dflt_stim();
    tmpl.ferr = 1'b1;
    row(mk_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP),
        PL_ALU, 5'd1, 5'd2, 5'd3, 2'b11, 1'b1, 4'h1, 7'h00);
    // system flags
    tmpl = dflt_stim();
    row(mk_sys(12'h000, 5'd0, 3'd0, 5'd0),
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h0, 7'h01);
    row(mk_sys(12'h001, 5'd0, 3'd0, 5'd0),
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h0, 7'h02);
    row(mk_sys(12'h302, 5'd0, 3'd0, 5'd0),
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h0, 7'h04);
    row(mk_sys(12'h105, 5'd0, 3'd0, 5'd0),   // wfi
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h0, 7'h10);
    row(mk_r(7'h00, 5'd0, 5'd0, 3'd1, 5'd0, OPCODE_MISC_MEM),   // fence.i
        PL_LOCAL, 5'd0, 5'd0, 5'd0, 2'b00, 1'b0, 4'h0, 7'h20);
    row(mk_sys(12'h300, 5'd6, 3'd1, 5'd5),   // csrrw x5, mstatus, x6
        PL_MULT, 5'd6, 5'd0, 5'd5, 2'b01, 1'b1, 4'h0, 7'h40);
  endtask

  initial begin
    int cnt;
    void'($urandom(32'h9912172c));
    tmpl = dflt_stim();
    drive(tmpl, 1'b1);   // valid in the first reset cycle must not reach valid_o
    build_table();

    // outputs stay cleared while reset is held
    cnt = 0;
    @(posedge clk_i);
    #1;
    while (rst_n_i !== 1'b1) begin
      if (cnt == 20) begin
        $display("reset was not released within 20 clock cycles");
        $display("Test FAILED");
        $fatal(1);
      end
      check_val("valid_o", 32'(valid_o), 32'h0);
      check_val("pc_nxt_o", pc_nxt_o, 32'h0);
      valid_i = 1'b0;
      @(posedge clk_i);
      #1;
      cnt++;
    end
    check_val("valid_o", 32'(valid_o), 32'h0);

    for (int i = 0; i < stim_q.size(); i++) begin
      if (($urandom % 32'd4) == 32'd0) begin
        idle_cycle();
      end
      advance();
      drive(stim_q[i], 1'b1);
      pend_q.push_back(exp_q[i]);
    end
    idle_cycle();
    advance();   // last idle cycle

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;   // 8 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_n_o = 1'b1;   // released just after the 4th edge
  end

endmodule

`default_nettype wire

/* ir_decoder.f */
rtl/ir_decoder_pkg.sv
rtl/dec_if.sv
rtl/opcode_decoder.sv
rtl/fetch_bounds_check.sv
rtl/dec_result_reg.sv
rtl/ir_decoder.sv
dv/tb_clk_gen.sv
dv/ir_decoder_props.sv
dv/ir_decoder_tb.sv

/* rtl/dec_if.sv */
`default_nettype none

interface dec_if;
  import ir_decoder_pkg::*;

  logic [PL_W-1:0]       pl_type;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rf_ren_a;
  logic                  rf_ren_b;
  logic                  rf_we;
  logic                  illegal_insn;   // includes the cheriot register rule
  logic [SYSCTL_W-1:0]   sysctl;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_jalr;

  modport dec (output pl_type, rs1, rs2, rd, rf_ren_a, rf_ren_b, rf_we,
               illegal_insn, sysctl, is_branch, is_jal, is_jalr);
  modport res (input  pl_type, rs1, rs2, rd, rf_ren_a, rf_ren_b, rf_we,
               illegal_insn, sysctl, is_branch, is_jal, is_jalr);

endinterface

`default_nettype wire

/* rtl/dec_result_reg.sv */
`default_nettype none

module dec_result_reg (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 valid_i,
  dec_if.res                                   dec_i,
  input  logic [ir_decoder_pkg::XLEN-1:0]      insn_i,
  input  logic [ir_decoder_pkg::XLEN-1:0]      pc_i,
  input  logic                                 is_comp_i,
  input  logic                                 fetch_err_i,
  input  logic                                 bound_vio_i,
  input  logic                                 perm_vio_i,
  input  logic                                 sr_missing_i,
  output logic                                 valid_o,
  output logic [ir_decoder_pkg::PL_W-1:0]      pl_type_o,
  output logic [ir_decoder_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [ir_decoder_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [ir_decoder_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [1:0]                           rf_ren_o,
  output logic                                 rf_we_o,
  output logic                                 illegal_insn_o,
  output logic                                 perm_vio_o,
  output logic                                 bound_vio_o,
  output logic                                 fetch_err_o,
  output logic                                 any_err_o,
  output logic                                 is_branch_o,
  output logic                                 is_jal_o,
  output logic                                 is_jalr_o,
  output logic [ir_decoder_pkg::SYSCTL_W-1:0]  sysctl_o,
  output logic [ir_decoder_pkg::XLEN-1:0]      pc_nxt_o,
  output logic [ir_decoder_pkg::XLEN-1:0]      btarget_o
);
  import ir_decoder_pkg::*;

  logic [XLEN-1:0] imm_j, imm_b;
  logic [XLEN-1:0] pc_nxt_d, btarget_d;
  logic            perm_vio_d, any_err_d;

  assign imm_j = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_b = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};

  assign pc_nxt_d  = pc_i + (is_comp_i ? XLEN'(2) : XLEN'(4));
  assign btarget_d = pc_i + (dec_i.is_jal ? imm_j : imm_b);

  // mret needs the system-register permission on top of the fetch checks
  assign perm_vio_d = perm_vio_i | (sr_missing_i & dec_i.sysctl[SYS_MRET]);
  assign any_err_d  = dec_i.illegal_insn | perm_vio_d | bound_vio_i | fetch_err_i;

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o        <= 1'b0;
      pl_type_o      <= '0;
      rs1_o          <= '0;
      rs2_o          <= '0;
      rd_o           <= '0;
      rf_ren_o       <= '0;
      rf_we_o        <= 1'b0;
      illegal_insn_o <= 1'b0;
      perm_vio_o     <= 1'b0;
      bound_vio_o    <= 1'b0;
      fetch_err_o    <= 1'b0;
      any_err_o      <= 1'b0;
      is_branch_o    <= 1'b0;
      is_jal_o       <= 1'b0;
      is_jalr_o      <= 1'b0;
      sysctl_o       <= '0;
      pc_nxt_o       <= '0;
      btarget_o      <= '0;
    end else begin
      valid_o        <= valid_i;   // data loads every cycle regardless
      pl_type_o      <= dec_i.pl_type;
      rs1_o          <= dec_i.rs1;
      rs2_o          <= dec_i.rs2;
      rd_o           <= dec_i.rd;
      rf_ren_o       <= {dec_i.rf_ren_b, dec_i.rf_ren_a};
      rf_we_o        <= dec_i.rf_we;
      illegal_insn_o <= dec_i.illegal_insn;
      perm_vio_o     <= perm_vio_d;
      bound_vio_o    <= bound_vio_i;
      fetch_err_o    <= fetch_err_i;
      any_err_o      <= any_err_d;
      is_branch_o    <= dec_i.is_branch;
      is_jal_o       <= dec_i.is_jal;
      is_jalr_o      <= dec_i.is_jalr;
      sysctl_o       <= dec_i.sysctl;
      pc_nxt_o       <= pc_nxt_d;
      btarget_o      <= btarget_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_bounds_check.sv */
`default_nettype none

module fetch_bounds_check (
  input  logic [ir_decoder_pkg::XLEN-1:0]    pc_i,
  input  logic                               is_comp_i,
  input  logic                               cheri_pmode_i,
  input  logic                               debug_mode_i,
  input  logic [ir_decoder_pkg::XLEN-1:0]    pcc_base_i,
  input  logic [ir_decoder_pkg::XLEN:0]      pcc_top_i,
  input  logic                               pcc_tag_i,
  input  logic                               pcc_perm_ex_i,
  input  logic                               pcc_perm_sr_i,
  input  logic [ir_decoder_pkg::OTYPE_W-1:0] pcc_otype_i,
  output logic                               bound_vio_o,
  output logic                               perm_vio_o,
  output logic                               sr_missing_o
);
  import ir_decoder_pkg::*;

  logic [XLEN+1:0] hdrm;   // top - pc, msb is the borrow
  logic            hdrm_ge2, hdrm_ge4, hdrm_ok;
  logic            base_ok, allow_all;
  logic            check_en;

  assign check_en = cheri_pmode_i & ~debug_mode_i;

  // full 32-bit space, lets pc 0xffff_fffe fetch a 32-bit insn
  assign allow_all = (pcc_base_i == '0) & pcc_top_i[XLEN];

  assign hdrm     = {1'b0, pcc_top_i} - {2'b00, pc_i};
  assign hdrm_ge4 = ~hdrm[XLEN+1] & (|hdrm[XLEN:2]);
  assign hdrm_ge2 = ~hdrm[XLEN+1] & (|hdrm[XLEN:1]);
  assign hdrm_ok  = allow_all | (is_comp_i ? hdrm_ge2 : hdrm_ge4);
  assign base_ok  = (pc_i >= pcc_base_i);

  assign bound_vio_o  = check_en & (~base_ok | ~hdrm_ok);
  assign perm_vio_o   = check_en & (~pcc_perm_ex_i | ~pcc_tag_i | (pcc_otype_i != '0));
  assign sr_missing_o = check_en & ~pcc_perm_sr_i;   // only matters for mret

endmodule

`default_nettype wire

/* rtl/ir_decoder.sv */
`default_nettype none

module ir_decoder (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  valid_i,
  input  logic [ir_decoder_pkg::XLEN-1:0]       insn_i,
  input  logic [ir_decoder_pkg::XLEN-1:0]       pc_i,
  input  logic                                  is_comp_i,
  input  logic                                  fetch_err_i,
  input  logic                                  cheri_pmode_i,
  input  logic                                  debug_mode_i,
  input  logic [ir_decoder_pkg::XLEN-1:0]       pcc_base_i,
  input  logic [ir_decoder_pkg::XLEN:0]         pcc_top_i,
  input  logic                                  pcc_tag_i,
  input  logic                                  pcc_perm_ex_i,
  input  logic                                  pcc_perm_sr_i,
  input  logic [ir_decoder_pkg::OTYPE_W-1:0]    pcc_otype_i,
  output logic                                  valid_o,
  output logic [ir_decoder_pkg::PL_W-1:0]       pl_type_o,
  output logic [ir_decoder_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [ir_decoder_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [ir_decoder_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [1:0]                            rf_ren_o,   // {b, a}
  output logic                                  rf_we_o,
  output logic                                  illegal_insn_o,
  output logic                                  perm_vio_o,
  output logic                                  bound_vio_o,
  output logic                                  fetch_err_o,
  output logic                                  any_err_o,
  output logic                                  is_branch_o,
  output logic                                  is_jal_o,
  output logic                                  is_jalr_o,
  output logic [ir_decoder_pkg::SYSCTL_W-1:0]   sysctl_o,
  output logic [ir_decoder_pkg::XLEN-1:0]       pc_nxt_o,
  output logic [ir_decoder_pkg::XLEN-1:0]       btarget_o
);

  logic bound_vio, perm_vio, sr_missing;

  dec_if i_dec_if ();

  opcode_decoder #(
    .RV32M (1'b1)
  ) i_opcode_decoder (
    .insn_i        (insn_i),
    .cheri_pmode_i (cheri_pmode_i),
    .dec_o         (i_dec_if.dec)
  );

  // pc against pcc, runs beside the opcode decode
  fetch_bounds_check i_fetch_bounds_check (
    .pc_i          (pc_i),
    .is_comp_i     (is_comp_i),
    .cheri_pmode_i (cheri_pmode_i),
    .debug_mode_i  (debug_mode_i),
    .pcc_base_i    (pcc_base_i),
    .pcc_top_i     (pcc_top_i),
    .pcc_tag_i     (pcc_tag_i),
    .pcc_perm_ex_i (pcc_perm_ex_i),
    .pcc_perm_sr_i (pcc_perm_sr_i),
    .pcc_otype_i   (pcc_otype_i),
    .bound_vio_o   (bound_vio),
    .perm_vio_o    (perm_vio),
    .sr_missing_o  (sr_missing)
  );

  dec_result_reg i_dec_result_reg (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .dec_i          (i_dec_if.res),
    .insn_i         (insn_i),
    .pc_i           (pc_i),
    .is_comp_i      (is_comp_i),
    .fetch_err_i    (fetch_err_i),
    .bound_vio_i    (bound_vio),
    .perm_vio_i     (perm_vio),
    .sr_missing_i   (sr_missing),
    .valid_o        (valid_o),
    .pl_type_o      (pl_type_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .rd_o           (rd_o),
    .rf_ren_o       (rf_ren_o),
    .rf_we_o        (rf_we_o),
    .illegal_insn_o (illegal_insn_o),
    .perm_vio_o     (perm_vio_o),
    .bound_vio_o    (bound_vio_o),
    .fetch_err_o    (fetch_err_o),
    .any_err_o      (any_err_o),
    .is_branch_o    (is_branch_o),
    .is_jal_o       (is_jal_o),
    .is_jalr_o      (is_jalr_o),
    .sysctl_o       (sysctl_o),
    .pc_nxt_o       (pc_nxt_o),
    .btarget_o      (btarget_o)
  );

endmodule

`default_nettype wire

/* rtl/ir_decoder_pkg.sv */
`default_nettype none

package ir_decoder_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned OTYPE_W    = 3;

  //////////////////////////////////////////////////////////////////////
  // base opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_LOAD     = 7'h03;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'h0f;
  localparam logic [6:0] OPCODE_OP_IMM   = 7'h13;
  localparam logic [6:0] OPCODE_AUIPC    = 7'h17;
  localparam logic [6:0] OPCODE_STORE    = 7'h23;
  localparam logic [6:0] OPCODE_OP       = 7'h33;
  localparam logic [6:0] OPCODE_LUI      = 7'h37;
  localparam logic [6:0] OPCODE_BRANCH   = 7'h63;
  localparam logic [6:0] OPCODE_JALR     = 7'h67;
  localparam logic [6:0] OPCODE_JAL      = 7'h6f;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'h73;

  // pipeline class
  localparam int unsigned PL_W = 3;

  localparam logic [PL_W-1:0] PL_ALU   = 3'd0;
  localparam logic [PL_W-1:0] PL_LS    = 3'd1;
  localparam logic [PL_W-1:0] PL_MULT  = 3'd2;   // multiplier and csr path
  localparam logic [PL_W-1:0] PL_LOCAL = 3'd3;
  localparam logic [PL_W-1:0] PL_JAL   = 3'd4;
  localparam logic [PL_W-1:0] PL_JALR  = 3'd5;

  // bit positions in the sysctl vector
  localparam int unsigned SYSCTL_W   = 7;

  localparam int unsigned SYS_ECALL  = 0;
  localparam int unsigned SYS_EBRK   = 1;
  localparam int unsigned SYS_MRET   = 2;
  localparam int unsigned SYS_DRET   = 3;
  localparam int unsigned SYS_WFI    = 4;
  localparam int unsigned SYS_FENCEI = 5;
  localparam int unsigned SYS_CSR    = 6;

  //////////////////////////////////////////////////////////////////////
  // instruction word, register form and system form
  //////////////////////////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           funct12;   // csr address or system function
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } s;
  } insn_word_u;

endpackage

`default_nettype wire

/* rtl/opcode_decoder.sv */
`default_nettype none

module opcode_decoder #(
  parameter bit RV32M = 1'b1
) (
  input  logic [ir_decoder_pkg::XLEN-1:0] insn_i,
  input  logic                            cheri_pmode_i,
  dec_if.dec                              dec_o
);
  import ir_decoder_pkg::*;

  insn_word_u            insn;
  logic [PL_W-1:0]       pl_type;
  logic                  rf_ren_a, rf_ren_b, rf_we;
  logic                  ren_a_ok, ren_b_ok, we_ok;
  logic                  illegal_insn, illegal_reg;
  logic [SYSCTL_W-1:0]   sysctl;
  logic [REG_ADDR_W-1:0] addr_mask;

  assign insn = insn_i;

  //////////////////////////////////////////////////////////////////////
  // opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pl_type      = PL_ALU;
    rf_ren_a     = 1'b0;
    rf_ren_b     = 1'b0;
    rf_we        = 1'b0;
    illegal_insn = 1'b0;
    sysctl       = '0;

    unique case (insn.r.opcode)
      OPCODE_JAL: begin
        pl_type = PL_JAL;
        rf_we   = 1'b1;
      end
      OPCODE_JALR: begin
        pl_type      = PL_JALR;
        rf_ren_a     = 1'b1;
        rf_we        = 1'b1;
        illegal_insn = (insn.r.funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        pl_type      = PL_LOCAL;
        rf_ren_a     = 1'b1;
        rf_ren_b     = 1'b1;
        illegal_insn = (insn.r.funct3[2:1] == 2'b01);   // funct3 2 and 3
      end
      OPCODE_LOAD: begin
        pl_type      = PL_LS;
        rf_ren_a     = 1'b1;
        rf_we        = 1'b1;
        illegal_insn = (insn.r.funct3[2:1] == 2'b11) || (insn.r.funct3 == 3'b011);
      end
      OPCODE_STORE: begin
        pl_type      = PL_LS;
        rf_ren_a     = 1'b1;
        rf_ren_b     = 1'b1;
        illegal_insn = insn.r.funct3[2] || (insn.r.funct3[1:0] == 2'b11);
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        rf_we = 1'b1;
      end
      OPCODE_OP_IMM: begin
        rf_ren_a = 1'b1;
        rf_we    = 1'b1;
        // only the shifts constrain funct7
        if (insn.r.funct3 == 3'b001) begin
          illegal_insn = (insn.r.funct7 != 7'h00);
        end else if (insn.r.funct3 == 3'b101) begin
          illegal_insn = (insn.r.funct7 != 7'h00) && (insn.r.funct7 != 7'h20);
        end
      end
      OPCODE_OP: begin
        rf_ren_a = 1'b1;
        rf_ren_b = 1'b1;
        rf_we    = 1'b1;
        case ({insn.r.funct7, insn.r.funct3})
          {7'h00, 3'b000}, {7'h20, 3'b000},   // add, sub
          {7'h00, 3'b001}, {7'h00, 3'b010},
          {7'h00, 3'b011}, {7'h00, 3'b100},
          {7'h00, 3'b101}, {7'h20, 3'b101},   // srl, sra
          {7'h00, 3'b110}, {7'h00, 3'b111}: begin
            pl_type = PL_ALU;
          end
          default: begin
            if (insn.r.funct7 == 7'h01) begin   // mul/div group
              pl_type      = PL_MULT;
              illegal_insn = ~RV32M;
            end else begin
              illegal_insn = 1'b1;
            end
          end
        endcase
      end
      OPCODE_MISC_MEM: begin
        pl_type = PL_LOCAL;
        if (insn.r.funct3 == 3'b001) begin
          sysctl[SYS_FENCEI] = 1'b1;
        end else if (insn.r.funct3 != 3'b000) begin
          illegal_insn = 1'b1;
        end
      end
      OPCODE_SYSTEM: begin
        if (insn.s.funct3 == 3'b000) begin
          pl_type = PL_LOCAL;
          case (insn.s.funct12)
            12'h000: sysctl[SYS_ECALL] = 1'b1;
            12'h001: sysctl[SYS_EBRK]  = 1'b1;
            12'h302: sysctl[SYS_MRET]  = 1'b1;
            12'h7b2: sysctl[SYS_DRET]  = 1'b1;
            12'h105: sysctl[SYS_WFI]   = 1'b1;
            default: illegal_insn      = 1'b1;
          endcase
          if ((insn.s.rs1 != '0) || (insn.s.rd != '0)) begin
            illegal_insn = 1'b1;
          end
        end else begin
          // csr access, rd written even when zero
          pl_type         = PL_MULT;
          sysctl[SYS_CSR] = 1'b1;
          rf_ren_a        = ~insn.s.funct3[2];   // immediate forms skip rs1
          rf_we           = 1'b1;
          illegal_insn    = (insn.s.funct3[1:0] == 2'b00);
        end
      end
      default: illegal_insn = 1'b1;
    endcase
  end

  // cheriot mode only exposes x0..x15
  assign illegal_reg = cheri_pmode_i & ((rf_ren_a & insn.r.rs1[4]) |
                                        (rf_ren_b & insn.r.rs2[4]) |
                                        (rf_we    & insn.r.rd[4]));

  assign ren_a_ok  = rf_ren_a & ~illegal_reg;
  assign ren_b_ok  = rf_ren_b & ~illegal_reg;
  assign we_ok     = rf_we    & ~illegal_reg;
  assign addr_mask = {~cheri_pmode_i, 4'hf};

  assign dec_o.pl_type      = pl_type;
  assign dec_o.rs1          = ren_a_ok ? (insn.r.rs1 & addr_mask) : '0;
  assign dec_o.rs2          = ren_b_ok ? (insn.r.rs2 & addr_mask) : '0;
  assign dec_o.rd           = we_ok    ? (insn.r.rd  & addr_mask) : '0;
  assign dec_o.rf_ren_a     = ren_a_ok;
  assign dec_o.rf_ren_b     = ren_b_ok;
  assign dec_o.rf_we        = we_ok;
  assign dec_o.illegal_insn = illegal_insn | illegal_reg;
  assign dec_o.sysctl       = sysctl;
  assign dec_o.is_branch    = (insn.r.opcode == OPCODE_BRANCH);
  assign dec_o.is_jal       = (insn.r.opcode == OPCODE_JAL);
  assign dec_o.is_jalr      = (insn.r.opcode == OPCODE_JALR);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ir_decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module ir_decoder_tb \
  -f ir_decoder.f -o sim_ir_decoder \
  || { echo "verilator build failed"; exit 1; }

result=$(./obj_dir/sim_ir_decoder 2>&1)
echo "$result"
echo "$result" | grep -qx "Test OK" && exit 0 || exit 1
